/* include/tsio_defs.svh */
`ifndef TSIO_DEFS_SVH
`define TSIO_DEFS_SVH

// low address byte of the beeper and tape port
`define TSIO_PORT_FE          8'hfe

// covox sample ports, low address byte
`define TSIO_PORT_COVOX_L     8'h0f
`define TSIO_PORT_COVOX_R     8'h4f
// writes the same sample to both channels
`define TSIO_PORT_COVOX_MONO  8'hfb

// mixer weights of the one-bit sources
`define TSIO_SPK_LEVEL        16'h2000
`define TSIO_TAPE_LEVEL       16'h0800
`define TSIO_MIC_LEVEL        16'h0400

// covox byte sits at bits 13..6 of the sample
`define TSIO_COVOX_SHIFT      6

`endif

/* design/tsio_pkg.sv */
`default_nettype none

package tsio_pkg;

  // decoded target of an I/O cycle
  typedef enum logic [2:0] {
    sel_none,
    sel_fe,
    sel_covox_l,
    sel_covox_r,
    sel_covox_both
  } port_sel_e;

  // one write request, valid for a single clock
  typedef struct packed {
    logic      valid;
    port_sel_e sel;
    logic [7:0] data;
  } io_wr_t;

  // register contents the mixer works from
  typedef struct packed {
    logic       speaker;
    logic       mic;
    logic [7:0] covox_l;
    logic [7:0] covox_r;
  } sound_src_t;

  typedef enum logic [1:0] {
    mix_stereo = 2'd0,
    mix_mono   = 2'd1,
    mix_mute   = 2'd2,
    mix_swap   = 2'd3
  } mix_mode_e;

  typedef logic [15:0] sample_t;

endpackage

`default_nettype wire

/* design/io_port_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tsio_defs.svh"

module io_port_decode (
  input  logic             clk_28mhz,
  input  logic             rst,
  input  logic [15:0]      addr,
  input  logic [7:0]       data_in,
  input  logic             iorq_n,
  input  logic             rd_n,
  input  logic             wr_n,
  input  logic             m1_n,
  input  logic [4:0]       keyboard_data,
  input  logic             tape_in,
  input  logic             covox_en,
  output logic [7:0]       data_out,
  output logic [7:0]       keyboard_addr,
  output tsio_pkg::io_wr_t wr_req
);

  tsio_pkg::port_sel_e port_sel;
  tsio_pkg::port_sel_e wr_sel;
  logic                io_rd;
  logic                io_wr;
  logic [1:0]          wr_sync;
  logic                wr_prev;
  logic                wr_start;
  logic                wr_valid;
  logic [7:0]          wr_data;

  // interrupt acknowledge cycles (m1_n low) never count as port access
  assign io_rd = ~iorq_n & ~rd_n & m1_n;
  assign io_wr = ~iorq_n & ~wr_n & m1_n;

  // keyboard row select comes straight from the high address byte
  assign keyboard_addr = addr[15:8];

  // covox ports decode only while enabled
  always_comb begin
    port_sel = tsio_pkg::sel_none;
    case (addr[7:0])
      `TSIO_PORT_FE: port_sel = tsio_pkg::sel_fe;
      `TSIO_PORT_COVOX_L: begin
        if (covox_en)
          port_sel = tsio_pkg::sel_covox_l;
      end
      `TSIO_PORT_COVOX_R: begin
        if (covox_en)
          port_sel = tsio_pkg::sel_covox_r;
      end
      `TSIO_PORT_COVOX_MONO: begin
        if (covox_en)
          port_sel = tsio_pkg::sel_covox_both;
      end
      default: port_sel = tsio_pkg::sel_none;
    endcase
  end

  // two-flop sync of the write strobe, then rising edge detect
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      wr_sync  <= 2'b00;
      wr_prev  <= 1'b0;
      wr_valid <= 1'b0;
    end else begin
      wr_sync  <= {wr_sync[0], io_wr};
      wr_prev  <= wr_sync[1];
      wr_valid <= wr_start;
    end
  end

  assign wr_start = wr_sync[1] & ~wr_prev;

  // bus is still held here since strobes stay low 3 clocks minimum
  always_ff @(posedge clk_28mhz) begin
    if (wr_start) begin
      wr_sel  <= port_sel;
      wr_data <= data_in;
    end
  end

  assign wr_req.valid = wr_valid;
  assign wr_req.sel   = wr_sel;
  assign wr_req.data  = wr_data;

  // bits 7 and 5 of a #FE read float high on the real machine
  always_comb begin
    data_out = 8'hff;
    if (io_rd && port_sel == tsio_pkg::sel_fe)
      data_out = {1'b1, tape_in, 1'b1, keyboard_data};
  end

endmodule

`default_nettype wire

/* design/port_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module port_regs (
  input  logic                 clk_28mhz,
  input  logic                 rst,
  input  tsio_pkg::io_wr_t     wr_req,
  output logic                 tape_out,
  output logic                 beep,
  output tsio_pkg::sound_src_t src
);

  // border and spare bits in 2..0 are stored and never read
  logic [7:0] port_fe;
  logic [7:0] covox_l;
  logic [7:0] covox_r;

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      port_fe <= 8'h00;
      covox_l <= 8'h00;
      covox_r <= 8'h00;
    end else if (wr_req.valid) begin
      case (wr_req.sel)
        tsio_pkg::sel_fe: begin
          port_fe <= wr_req.data;
        end
        tsio_pkg::sel_covox_l: begin
          covox_l <= wr_req.data;
        end
        tsio_pkg::sel_covox_r: begin
          covox_r <= wr_req.data;
        end
        tsio_pkg::sel_covox_both: begin
          covox_l <= wr_req.data;
          covox_r <= wr_req.data;
        end
        // unmapped port, nothing to load
        default: begin
        end
      endcase
    end
  end

  // bit 3 is the mic / tape output, bit 4 the speaker
  assign tape_out = port_fe[3];
  assign beep     = port_fe[4];

  assign src.speaker = port_fe[4];
  assign src.mic     = port_fe[3];
  assign src.covox_l = covox_l;
  assign src.covox_r = covox_r;

endmodule

`default_nettype wire

/* design/audio_mixer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tsio_defs.svh"

module audio_mixer (
  input  logic                 clk_28mhz,
  input  logic                 rst,
  input  tsio_pkg::sound_src_t src,
  input  logic                 tape_in,
  input  tsio_pkg::mix_mode_e  mix_mode,
  output tsio_pkg::sample_t    audio_out_l,
  output tsio_pkg::sample_t    audio_out_r
);

  tsio_pkg::sample_t raw_l;
  tsio_pkg::sample_t raw_r;
  tsio_pkg::sample_t mix_l;
  tsio_pkg::sample_t mix_r;
  logic [16:0]       mono_sum;

  // a single channel peaks at 27584 and never wraps 16 bits
  function automatic tsio_pkg::sample_t channel_level(
    input logic [7:0] covox,
    input logic       speaker,
    input logic       tape,
    input logic       mic
  );
    tsio_pkg::sample_t level;
    level = tsio_pkg::sample_t'(covox) << `TSIO_COVOX_SHIFT;
    if (speaker)
      level = level + `TSIO_SPK_LEVEL;
    if (tape)
      level = level + `TSIO_TAPE_LEVEL;
    if (mic)
      level = level + `TSIO_MIC_LEVEL;
    return level;
  endfunction

  always_comb begin
    raw_l = channel_level(src.covox_l, src.speaker, tape_in, src.mic);
    raw_r = channel_level(src.covox_r, src.speaker, tape_in, src.mic);
  end

  // extra bit keeps the carry before halving
  assign mono_sum = {1'b0, raw_l} + {1'b0, raw_r};

  always_comb begin
    mix_l = raw_l;
    mix_r = raw_r;
    case (mix_mode)
      tsio_pkg::mix_stereo: begin
        mix_l = raw_l;
        mix_r = raw_r;
      end
      tsio_pkg::mix_mono: begin
        mix_l = mono_sum[16:1];
        mix_r = mono_sum[16:1];
      end
      tsio_pkg::mix_mute: begin
        mix_l = 16'h0000;
        mix_r = 16'h0000;
      end
      tsio_pkg::mix_swap: begin
        mix_l = raw_r;
        mix_r = raw_l;
      end
    endcase
  end

  // output stage
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      audio_out_l <= 16'h0000;
      audio_out_r <= 16'h0000;
    end else begin
      audio_out_l <= mix_l;
      audio_out_r <= mix_r;
    end
  end

endmodule

`default_nettype wire

/* design/tsio_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tsio_top (
  input  logic        clk_28mhz,
  input  logic        rst,
  input  logic [15:0] addr,
  input  logic [7:0]  data_in,
  input  logic        iorq_n,
  input  logic        rd_n,
  input  logic        wr_n,
  input  logic        m1_n,
  input  logic [4:0]  keyboard_data,
  input  logic        tape_in,
  input  logic        covox_en,
  input  logic [1:0]  psg_mix,
  output logic [7:0]  data_out,
  output logic [7:0]  keyboard_addr,
  output logic        tape_out,
  output logic        beep,
  output logic [15:0] audio_out_l,
  output logic [15:0] audio_out_r
);

  tsio_pkg::io_wr_t     wr_req;
  tsio_pkg::sound_src_t src;

  // bus capture and decode
  io_port_decode u_decode (
    .clk_28mhz     (clk_28mhz),
    .rst           (rst),
    .addr          (addr),
    .data_in       (data_in),
    .iorq_n        (iorq_n),
    .rd_n          (rd_n),
    .wr_n          (wr_n),
    .m1_n          (m1_n),
    .keyboard_data (keyboard_data),
    .tape_in       (tape_in),
    .covox_en      (covox_en),
    .data_out      (data_out),
    .keyboard_addr (keyboard_addr),
    .wr_req        (wr_req)
  );

  port_regs u_regs (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .wr_req    (wr_req),
    .tape_out  (tape_out),
    .beep      (beep),
    .src       (src)
  );

  // psg_mix encoding matches mix_mode_e directly
  audio_mixer u_mixer (
    .clk_28mhz   (clk_28mhz),
    .rst         (rst),
    .src         (src),
    .tape_in     (tape_in),
    .mix_mode    (tsio_pkg::mix_mode_e'(psg_mix)),
    .audio_out_l (audio_out_l),
    .audio_out_r (audio_out_r)
  );

endmodule

`default_nettype wire

/* dv/tb_tsio.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tsio_defs.svh"

module tb_tsio;

  // about 40 bus operations of 10 clocks each leave plenty of margin
  localparam int MAX_CYCLES = 3000;

  logic        clk_28mhz = 1'b0;
  logic        rst;
  logic [15:0] addr;
  logic [7:0]  data_in;
  logic        iorq_n;
  logic        rd_n;
  logic        wr_n;
  logic        m1_n;
  logic [4:0]  keyboard_data;
  logic        tape_in;
  logic        covox_en;
  logic [1:0]  psg_mix;
  logic [7:0]  data_out;
  logic [7:0]  keyboard_addr;
  logic        tape_out;
  logic        beep;
  logic [15:0] audio_out_l;
  logic [15:0] audio_out_r;

  // reference model of the port registers
  logic [7:0]  model_fe;
  logic [7:0]  model_cl;
  logic [7:0]  model_cr;

  integer      seed;
  integer      errors;
  integer      checks;
  integer      cycles;

  tsio_top DUT (
    .clk_28mhz     (clk_28mhz),
    .rst           (rst),
    .addr          (addr),
    .data_in       (data_in),
    .iorq_n        (iorq_n),
    .rd_n          (rd_n),
    .wr_n          (wr_n),
    .m1_n          (m1_n),
    .keyboard_data (keyboard_data),
    .tape_in       (tape_in),
    .covox_en      (covox_en),
    .psg_mix       (psg_mix),
    .data_out      (data_out),
    .keyboard_addr (keyboard_addr),
    .tape_out      (tape_out),
    .beep          (beep),
    .audio_out_l   (audio_out_l),
    .audio_out_r   (audio_out_r)
  );

  always #20 clk_28mhz = ~clk_28mhz;

  always @(posedge clk_28mhz) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("simulation timed out after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [15:0] expected_channel(input logic [7:0] covox,
      input logic spk, input logic tape, input logic mic);
    logic [15:0] lvl;
    lvl = ({8'h00, covox} << `TSIO_COVOX_SHIFT)
          + (spk ? `TSIO_SPK_LEVEL : 16'h0000)
          + (tape ? `TSIO_TAPE_LEVEL : 16'h0000)
          + (mic ? `TSIO_MIC_LEVEL : 16'h0000);
    return lvl;
  endfunction

  // {left, right} after the channel mode
  function automatic logic [31:0] expected_mix(input logic [1:0] mode);
    logic [15:0] l;
    logic [15:0] r;
    logic [16:0] sum;
    l = expected_channel(model_cl, model_fe[4], tape_in, model_fe[3]);
    r = expected_channel(model_cr, model_fe[4], tape_in, model_fe[3]);
    sum = {1'b0, l} + {1'b0, r};
    case (mode)
      2'd1: return {sum[16:1], sum[16:1]};
      2'd2: return 32'h0000_0000;
      2'd3: return {r, l};
      default: return {l, r};
    endcase
  endfunction

  task automatic check_eq(input logic [15:0] got, input logic [15:0] exp, input string what);
    checks = checks + 1;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic check_outputs(input string what);
    logic [31:0] exp;
    exp = expected_mix(psg_mix);
    check_eq(16'(tape_out), 16'(model_fe[3]), {what, ": tape_out"});
    check_eq(16'(beep), 16'(model_fe[4]), {what, ": beep"});
    check_eq(audio_out_l, exp[31:16], {what, ": audio_out_l"});
    check_eq(audio_out_r, exp[15:0], {what, ": audio_out_r"});
  endtask

  task automatic settle(input int n);
    repeat (n) @(negedge clk_28mhz);
  endtask

  task automatic update_model(input logic [7:0] port, input logic [7:0] d, input logic m1);
    if (m1) begin
      case (port)
        `TSIO_PORT_FE: begin
          model_fe = d;
        end
        `TSIO_PORT_COVOX_L: begin
          if (covox_en)
            model_cl = d;
        end
        `TSIO_PORT_COVOX_R: begin
          if (covox_en)
            model_cr = d;
        end
        `TSIO_PORT_COVOX_MONO: begin
          if (covox_en) begin
            model_cl = d;
            model_cr = d;
          end
        end
        default: begin
        end
      endcase
    end
  endtask

  // strobes low 4 clocks, high 4 clocks, then 2 more before any check
  task automatic bus_write(input logic [15:0] a, input logic [7:0] d, input logic m1);
    addr    = a;
    data_in = d;
    m1_n    = m1;
    iorq_n  = 1'b0;
    wr_n    = 1'b0;
    settle(4);
    iorq_n  = 1'b1;
    wr_n    = 1'b1;
    m1_n    = 1'b1;
    settle(4);
    update_model(a[7:0], d, m1);
    settle(2);
  endtask

  task automatic bus_read(input logic [15:0] a, input logic m1, output logic [7:0] value,
      output logic [7:0] row);
    addr   = a;
    m1_n   = m1;
    iorq_n = 1'b0;
    rd_n   = 1'b0;
    settle(2);
    value  = data_out;
    row    = keyboard_addr;
    settle(2);
    iorq_n = 1'b1;
    rd_n   = 1'b1;
    m1_n   = 1'b1;
    settle(4);
  endtask

  initial begin
    logic [31:0] rnd;
    logic [15:0] a;
    logic [15:0] prev_l;
    logic [15:0] prev_r;
    logic [7:0]  rd_val;
    logic [7:0]  rd_row;
    seed = 32'hf8d5_80d6;
    errors = 0;
    checks = 0;
    cycles = 0;
    model_fe = 8'h00;
    model_cl = 8'h00;
    model_cr = 8'h00;
    rst = 1'b1;
    addr = 16'h0000;
    data_in = 8'h00;
    iorq_n = 1'b1;
    rd_n = 1'b1;
    wr_n = 1'b1;
    m1_n = 1'b1;
    keyboard_data = 5'h00;
    tape_in = 1'b0;
    covox_en = 1'b0;
    psg_mix = 2'd0;
    settle(3);
    rst = 1'b0;
    settle(2);

    // state right after reset
    check_outputs("after reset, tape_in low");
    tape_in = 1'b1;
    settle(2);
    check_eq(audio_out_l, `TSIO_TAPE_LEVEL, "after reset, tape_in high: left");
    check_eq(audio_out_r, `TSIO_TAPE_LEVEL, "after reset, tape_in high: right");

    // speaker and tape output through #FE
    for (int i = 0; i < 12; i++) begin
      rnd = $random(seed);
      tape_in = rnd[24];
      bus_write({rnd[15:8], `TSIO_PORT_FE}, rnd[7:0], 1'b1);
      check_outputs("write #FE");
    end

    // covox ports while enabled
    covox_en = 1'b1;
    for (int i = 0; i < 12; i++) begin
      rnd = $random(seed);
      case (rnd[17:16])
        2'd0: a = {rnd[15:8], `TSIO_PORT_COVOX_L};
        2'd1: a = {rnd[15:8], `TSIO_PORT_COVOX_R};
        default: a = {rnd[15:8], `TSIO_PORT_COVOX_MONO};
      endcase
      bus_write(a, rnd[7:0], 1'b1);
      check_outputs("covox write, enabled");
    end

    // same ports ignored while disabled
    covox_en = 1'b0;
    for (int i = 0; i < 6; i++) begin
      rnd = $random(seed);
      prev_l = audio_out_l;
      prev_r = audio_out_r;
      case (i % 3)
        0: a = {rnd[15:8], `TSIO_PORT_COVOX_L};
        1: a = {rnd[15:8], `TSIO_PORT_COVOX_R};
        default: a = {rnd[15:8], `TSIO_PORT_COVOX_MONO};
      endcase
      bus_write(a, rnd[7:0], 1'b1);
      check_eq(audio_out_l, prev_l, "covox disabled: left unchanged");
      check_eq(audio_out_r, prev_r, "covox disabled: right unchanged");
      check_outputs("covox write, disabled");
    end

    // every channel mode over distinct left and right samples
    covox_en = 1'b1;
    bus_write({8'h00, `TSIO_PORT_COVOX_L}, 8'h5a, 1'b1);
    bus_write({8'h00, `TSIO_PORT_COVOX_R}, 8'hc3, 1'b1);
    bus_write({8'h00, `TSIO_PORT_FE}, 8'h18, 1'b1);
    for (int m = 0; m < 4; m++) begin
      psg_mix = 2'(m);
      settle(2);
      check_outputs("channel mode");
    end
    psg_mix = 2'd0;

    // port reads
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      keyboard_data = rnd[4:0];
      tape_in = rnd[5];
      bus_read({rnd[15:8], `TSIO_PORT_FE}, 1'b1, rd_val, rd_row);
      check_eq(16'(rd_val), 16'({1'b1, tape_in, 1'b1, keyboard_data}), "read #FE");
      check_eq(16'(rd_row), 16'(rnd[15:8]), "keyboard_addr");
    end
    bus_read({8'h12, `TSIO_PORT_COVOX_L}, 1'b1, rd_val, rd_row);
    check_eq(16'(rd_val), 16'h00ff, "read #0F");
    bus_read(16'h7f1f, 1'b1, rd_val, rd_row);
    check_eq(16'(rd_val), 16'h00ff, "read unmapped port");
    bus_read({8'hfe, `TSIO_PORT_FE}, 1'b0, rd_val, rd_row);
    check_eq(16'(rd_val), 16'h00ff, "read #FE with m1_n low");
    check_eq(16'(data_out), 16'h00ff, "idle bus");

    // interrupt acknowledge writes are ignored
    bus_write({8'h00, `TSIO_PORT_FE}, ~model_fe, 1'b0);
    check_outputs("write #FE with m1_n low");
    bus_write({8'h00, `TSIO_PORT_COVOX_MONO}, ~model_cl, 1'b0);
    check_outputs("covox write with m1_n low");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
design/tsio_pkg.sv
design/io_port_decode.sv
design/port_regs.sv
design/audio_mixer.sv
design/tsio_top.sv
dv/tb_tsio.sv

/* run_sim.sh */
#!/bin/sh
# build and run the tsio testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f sources.f --top-module tb_tsio -o tb_tsio > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_tsio > sim.log 2>&1
cat sim.log

grep -q "^TEST PASSED$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
